//--- soc_interconnect.f
+incdir+verilog
verilog/soc_xbar_pkg.sv
verilog/tcdm_addr_decoder.sv
verilog/tcdm_port_arbiter.sv
verilog/tcdm_response_router.sv
verilog/soc_interconnect.sv
bench/soc_interconnect_properties.sv
bench/soc_interconnect_checker.sv
bench/tb_soc_interconnect.sv

//--- Makefile
# Verilator build and run of the interconnect testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_soc_interconnect
FILELIST  ?= soc_interconnect.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST) $(shell sed -n '/^[^+]/p' $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJDIR)

//--- bench/tb_soc_interconnect.sv
// Testbench for the TCDM interconnect with random masters and memory slaves
// Both masters share one random stream, so the run is repeatable from the seed
// Slave models grant at random and answer one cycle after every grant
// Memory words that were never written read back a fill pattern of the address
`timescale 1ns/1ps
`include "soc_xbar_macros.svh"

module tb_soc_interconnect;

    localparam int unsigned NM = `SOC_NR_MASTERS;
    localparam int unsigned NS = `SOC_NR_SLAVES;
    localparam int unsigned NR_REQ = 2000;
    // Upper bound of the whole run at 20 cycles of 10 ns per request
    localparam longint unsigned WATCHDOG_NS = NR_REQ * 20 * 10;

    logic clk_i = 1'b0;
    logic rst_n_i = 1'b0;
    integer seed = 32'hbb9a;

    soc_xbar_pkg::tcdm_req_t [NM-1:0] master_req = '0;
    soc_xbar_pkg::tcdm_rsp_t [NM-1:0] master_rsp;
    soc_xbar_pkg::tcdm_req_t [NS-1:0] slave_req;
    soc_xbar_pkg::tcdm_rsp_t [NS-1:0] slave_rsp = '0;

    // Requests handed out per master so far
    int unsigned sent [NM];
    // Word-addressed contents of all slave memories together
    logic [31:0] slave_mem [logic [31:0]];

    soc_interconnect u_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .master_req_i (master_req),
        .master_rsp_o (master_rsp),
        .slave_req_o  (slave_req),
        .slave_rsp_i  (slave_rsp)
    );

    soc_interconnect_checker u_checker (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .master_req_i (master_req),
        .master_rsp_i (master_rsp),
        .slave_req_i  (slave_req),
        .slave_rsp_i  (slave_rsp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock, reset and end of run
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Masters are done once every request went out and was granted
        wait (sent[0] == NR_REQ && sent[1] == NR_REQ && !master_req[0].req && !master_req[1].req);
        repeat (5) @(posedge clk_i);
        u_checker.final_report();
        if (u_checker.err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the masters did not finish their requests in time");
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Master stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h6C3A_91E5;
    endfunction

    // Small address windows keep reads hitting words written before
    task automatic make_request(output soc_xbar_pkg::tcdm_req_t r);
        int unsigned kind;
        logic [31:0] rnd;
        kind = {$random(seed)} % 10;
        rnd  = $random(seed);
        r.req = 1'b1;
        if (kind < 4) begin
            r.add = `SOC_INTLV_BASE + (rnd & 32'h0000_00FC);
        end else if (kind < 8) begin
            r.add = `SOC_CONTIG_BASE + {19'd0, rnd[8], 12'd0} + (rnd & 32'h0000_003C);
        end else begin
            r.add = 32'h2000_0000 + (rnd & 32'h0000_FFFC);
        end
        r.wen   = rnd[20];
        r.be    = r.wen ? 4'hF : rnd[27:24];
        r.wdata = $random(seed);
    endtask

    always @(posedge clk_i or negedge rst_n_i) begin
        soc_xbar_pkg::tcdm_req_t nreq;
        if (!rst_n_i) begin
            master_req <= '0;
            for (int m = 0; m < NM; m++) begin
                sent[m] <= 0;
            end
        end else begin
            for (int m = 0; m < NM; m++) begin
                // A held request may only change after its grant
                if (!master_req[m].req || master_rsp[m].gnt) begin
                    if (sent[m] < NR_REQ && ({$random(seed)} % 4) != 0) begin
                        make_request(nreq);
                        master_req[m] <= nreq;
                        sent[m] <= sent[m] + 1;
                    end else begin
                        master_req[m] <= '0;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slave memory models
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_i or negedge rst_n_i) begin
        logic [31:0] word;
        logic [31:0] old;
        if (!rst_n_i) begin
            slave_rsp <= '0;
        end else begin
            for (int s = 0; s < NS; s++) begin
                slave_rsp[s].gnt   <= ({$random(seed)} % 10) < 7;
                slave_rsp[s].r_opc <= 1'b0;
                if (slave_req[s].req && slave_rsp[s].gnt) begin
                    word = slave_req[s].add >> 2;
                    old  = slave_mem.exists(word) ? slave_mem[word] : fill_word(word);
                    slave_rsp[s].r_valid <= 1'b1;
                    if (!slave_req[s].wen) begin
                        for (int b = 0; b < 4; b++) begin
                            if (slave_req[s].be[b]) begin
                                old[8*b +: 8] = slave_req[s].wdata[8*b +: 8];
                            end
                        end
                        slave_mem[word] = old;
                        slave_rsp[s].r_rdata <= 32'h0;
                    end else begin
                        slave_rsp[s].r_rdata <= old;
                    end
                end else begin
                    slave_rsp[s].r_valid <= 1'b0;
                    slave_rsp[s].r_rdata <= 32'h0;
                end
            end
        end
    end

endmodule

//--- bench/soc_interconnect_checker.sv
// Watches all DUT ports and compares them with a reference model
// All ports are sampled on the rising clock edge before the inputs change
// Keeps its own word-addressed memory and its own copy of the address map
`timescale 1ns/1ps
`include "soc_xbar_macros.svh"

module soc_interconnect_checker (
    input logic                                           clk_i,
    input logic                                           rst_n_i,
    input soc_xbar_pkg::tcdm_req_t [`SOC_NR_MASTERS-1:0]  master_req_i,
    input soc_xbar_pkg::tcdm_rsp_t [`SOC_NR_MASTERS-1:0]  master_rsp_i,
    input soc_xbar_pkg::tcdm_req_t [`SOC_NR_SLAVES-1:0]   slave_req_i,
    input soc_xbar_pkg::tcdm_rsp_t [`SOC_NR_SLAVES-1:0]   slave_rsp_i
);

    localparam int NM = `SOC_NR_MASTERS;
    localparam int NS = `SOC_NR_SLAVES;

    int unsigned err_count = 0;
    int unsigned check_count = 0;

    logic [31:0] ref_mem [logic [31:0]];
    // Expected responses per master where bit 33 asks for a data compare and bit 32 is r_opc
    logic [33:0] exp_q [NM][$];
    logic        valid_due [NM];
    // Grants that went to the other master at each port while this one waited
    int unsigned wait_cnt [NM][NS];

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h6C3A_91E5;
    endfunction

    // Slave port of an address or -1 when no region holds it
    function automatic int port_of(input logic [31:0] a);
        if (a >= `SOC_INTLV_BASE && a < `SOC_INTLV_BASE + `SOC_INTLV_SIZE) begin
            return int'(a[3:2]);
        end
        if (a >= `SOC_CONTIG_BASE && a < `SOC_CONTIG_BASE + 2 * `SOC_CONTIG_SIZE) begin
            return `SOC_NR_BANKS + int'(a[12]);
        end
        return -1;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        err_count++;
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
    endtask

    task automatic report_problem(input string msg);
        err_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Master side checks
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        int p;
        int gcount [NS];
        logic [31:0] word;
        logic [31:0] val;
        logic [33:0] e;
        if (!rst_n_i) begin
            for (int m = 0; m < NM; m++) begin
                valid_due[m] = 1'b0;
                for (int s = 0; s < NS; s++) begin
                    wait_cnt[m][s] = 0;
                end
            end
            if (master_rsp_i[0].gnt || master_rsp_i[1].gnt) begin
                report_problem("gnt raised while in reset");
            end
        end else begin
            for (int s = 0; s < NS; s++) begin
                gcount[s] = 0;
            end
            for (int m = 0; m < NM; m++) begin
                check_count++;
                if (master_rsp_i[m].r_valid !== valid_due[m]) begin
                    report_mismatch($sformatf("master_rsp_o[%0d].r_valid", m),
                                    {31'd0, valid_due[m]}, {31'd0, master_rsp_i[m].r_valid});
                end
                if (master_rsp_i[m].r_valid && exp_q[m].size() > 0) begin
                    e = exp_q[m].pop_front();
                    if (master_rsp_i[m].r_opc !== e[32]) begin
                        report_mismatch($sformatf("master_rsp_o[%0d].r_opc", m),
                                        {31'd0, e[32]}, {31'd0, master_rsp_i[m].r_opc});
                    end
                    if (e[33] && master_rsp_i[m].r_rdata !== e[31:0]) begin
                        report_mismatch($sformatf("master_rsp_o[%0d].r_rdata", m),
                                        e[31:0], master_rsp_i[m].r_rdata);
                    end
                end
                if (master_rsp_i[m].gnt && !master_req_i[m].req) begin
                    report_problem($sformatf("master %0d granted without a request", m));
                end
                p = port_of(master_req_i[m].add);
                if (master_req_i[m].req && p < 0 && !master_rsp_i[m].gnt) begin
                    report_mismatch($sformatf("master_rsp_o[%0d].gnt", m), 32'd1, 32'd0);
                end
                if (master_rsp_i[m].gnt && p >= 0) begin
                    gcount[p]++;
                    if (!slave_rsp_i[p].gnt) begin
                        report_problem($sformatf("master %0d granted while port %0d stalls",
                                                 m, p));
                    end
                    // The granted request must reach its slave with every field intact
                    if (slave_req_i[p] !== master_req_i[m]) begin
                        report_problem($sformatf("master %0d request altered at port %0d",
                                                 m, p));
                    end
                end
                if (master_req_i[m].req && master_rsp_i[m].gnt) begin
                    word = master_req_i[m].add >> 2;
                    val  = ref_mem.exists(word) ? ref_mem[word] : fill_word(word);
                    if (p < 0) begin
                        exp_q[m].push_back({2'b11, `SOC_ERROR_WORD});
                    end else if (master_req_i[m].wen) begin
                        exp_q[m].push_back({2'b10, val});
                    end else begin
                        for (int b = 0; b < 4; b++) begin
                            if (master_req_i[m].be[b]) begin
                                val[8*b +: 8] = master_req_i[m].wdata[8*b +: 8];
                            end
                        end
                        ref_mem[word] = val;
                        exp_q[m].push_back({2'b00, 32'h0});
                    end
                end
                valid_due[m] = master_rsp_i[m].gnt;
            end

            // Contention and round-robin fairness per port
            for (int s = 0; s < NS; s++) begin
                if (gcount[s] > 1) begin
                    report_problem($sformatf("port %0d granted more than one master", s));
                end
                for (int m = 0; m < NM; m++) begin
                    if (!master_req_i[m].req || port_of(master_req_i[m].add) != s
                        || master_rsp_i[m].gnt) begin
                        wait_cnt[m][s] = 0;
                    end else if (gcount[s] > 0) begin
                        wait_cnt[m][s]++;
                        if (wait_cnt[m][s] >= 2) begin
                            report_problem($sformatf("master %0d starved at port %0d", m, s));
                        end
                    end
                end
            end

            ////////////////////////////////////////////////////////////////////
            // Slave side checks
            ////////////////////////////////////////////////////////////////////

            for (int s = 0; s < NS; s++) begin
                // A slave port must never see a request that belongs elsewhere
                if (slave_req_i[s].req && port_of(slave_req_i[s].add) != s) begin
                    report_problem($sformatf("slave port %0d got address %h of another port",
                                             s, slave_req_i[s].add));
                end
                if (slave_req_i[s].req && slave_rsp_i[s].gnt && s < `SOC_NR_BANKS
                    && int'(slave_req_i[s].add[3:2]) != s) begin
                    report_problem($sformatf("bank %0d got a word of another bank", s));
                end
            end
        end
    end

    // Every granted request must have been answered by the end of the run
    task automatic final_report();
        for (int m = 0; m < NM; m++) begin
            if (exp_q[m].size() != 0) begin
                report_problem($sformatf("master %0d has %0d responses missing",
                                         m, exp_q[m].size()));
            end
        end
        $display("Checker: %0d cycle checks, %0d errors", check_count, err_count);
    endtask

endmodule

//--- bench/soc_interconnect_properties.sv
// Handshake assertions on the master ports of the interconnect
// Bound to every instance of the top level, checks are idle during reset
`timescale 1ns/1ps
`include "soc_xbar_macros.svh"

module soc_interconnect_properties (
    input logic                                           clk_i,
    input logic                                           rst_n_i,
    input soc_xbar_pkg::tcdm_req_t [`SOC_NR_MASTERS-1:0]  master_req_i,
    input soc_xbar_pkg::tcdm_rsp_t [`SOC_NR_MASTERS-1:0]  master_rsp_o
);

    for (genvar m = 0; m < `SOC_NR_MASTERS; m++) begin : gen_master
        // No grant without a pending request
        a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            master_rsp_o[m].gnt |-> master_req_i[m].req)
            else $error("gnt without req on master %0d", m);

        // The response follows one cycle after a grant
        a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            master_rsp_o[m].gnt |=> master_rsp_o[m].r_valid)
            else $error("r_valid missing after gnt on master %0d", m);

        // And at no other time
        a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            !master_rsp_o[m].gnt |=> !master_rsp_o[m].r_valid)
            else $error("r_valid without gnt on master %0d", m);
    end

endmodule

bind soc_interconnect soc_interconnect_properties u_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .master_req_i (master_req_i),
    .master_rsp_o (master_rsp_o)
);

//--- verilog/soc_interconnect.sv
// TCDM interconnect with two masters, four interleaved banks and two
// contiguous slaves, arbitrated round robin at every slave port
// Every slave must give r_valid exactly one cycle after its gnt
// Slave ports 0 to 3 are the banks, ports 4 and 5 the contiguous slaves
// Unmapped accesses are answered here with 0xBADACCE5 and r_opc set
`timescale 1ns/1ps
`include "soc_xbar_macros.svh"

module soc_interconnect (
    input  logic                                           clk_i,
    input  logic                                           rst_n_i,
    input  soc_xbar_pkg::tcdm_req_t [`SOC_NR_MASTERS-1:0]  master_req_i,
    output soc_xbar_pkg::tcdm_rsp_t [`SOC_NR_MASTERS-1:0]  master_rsp_o,
    output soc_xbar_pkg::tcdm_req_t [`SOC_NR_SLAVES-1:0]   slave_req_o,
    input  soc_xbar_pkg::tcdm_rsp_t [`SOC_NR_SLAVES-1:0]   slave_rsp_i
);

    // Decoded target of every master request
    soc_xbar_pkg::route_t [`SOC_NR_MASTERS-1:0] route;

    // Per slave port, the grant vector over the masters
    logic [`SOC_NR_SLAVES-1:0][`SOC_NR_MASTERS-1:0] gnt_all;
    // Same vectors one cycle later, marking the response cycle
    logic [`SOC_NR_SLAVES-1:0][`SOC_NR_MASTERS-1:0] granted_q_all;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode, one per master
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < `SOC_NR_MASTERS; m++) begin : gen_decoder
        tcdm_addr_decoder u_decoder (
            .req_i   (master_req_i[m]),
            .route_o (route[m])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration, one per slave port
    ////////////////////////////////////////////////////////////////////////////

    // Each arbiter sees all requests and keeps those routed to its own port
    for (genvar s = 0; s < `SOC_NR_SLAVES; s++) begin : gen_arbiter
        tcdm_port_arbiter #(
            .PORT_IDX (s)
        ) u_arbiter (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .req_i       (master_req_i),
            .route_i     (route),
            .slave_rsp_i (slave_rsp_i[s]),
            .slave_req_o (slave_req_o[s]),
            .gnt_o       (gnt_all[s]),
            .granted_q_o (granted_q_all[s])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response routing, one per master
    ////////////////////////////////////////////////////////////////////////////

    // Routers pick their own column out of the grant matrices
    for (genvar m = 0; m < `SOC_NR_MASTERS; m++) begin : gen_router
        tcdm_response_router #(
            .MASTER_IDX (m)
        ) u_router (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .req_i       (master_req_i[m]),
            .route_i     (route[m]),
            .gnt_i       (gnt_all),
            .granted_q_i (granted_q_all),
            .slave_rsp_i (slave_rsp_i),
            .rsp_o       (master_rsp_o[m])
        );
    end

endmodule : soc_interconnect

//--- verilog/tcdm_response_router.sv
// Response path for one master port
// Data comes from the slave that granted this master one cycle earlier
// Unmapped requests are granted at once and answered with the error word
// gnt_i and granted_q_i carry the full grant vectors of all arbiters
`timescale 1ns/1ps
`include "soc_xbar_macros.svh"

module tcdm_response_router #(
    parameter int unsigned MASTER_IDX = 0
) (
    input  logic                                                      clk_i,
    input  logic                                                      rst_n_i,
    input  soc_xbar_pkg::tcdm_req_t                                   req_i,
    input  soc_xbar_pkg::route_t                                      route_i,
    input  logic [`SOC_NR_SLAVES-1:0][`SOC_NR_MASTERS-1:0]            gnt_i,
    input  logic [`SOC_NR_SLAVES-1:0][`SOC_NR_MASTERS-1:0]            granted_q_i,
    input  soc_xbar_pkg::tcdm_rsp_t [`SOC_NR_SLAVES-1:0]              slave_rsp_i,
    output soc_xbar_pkg::tcdm_rsp_t                                   rsp_o
);

    localparam int unsigned NS = `SOC_NR_SLAVES;

    // This master's column of the grant matrices
    logic [NS-1:0] gnt_mine;
    logic [NS-1:0] granted_mine;

    // Request that goes to the error path in this cycle
    logic err_req;

    // Error response due in this cycle
    logic err_q;
    // Slave port whose answer is due in this cycle
    soc_xbar_pkg::slave_idx_t src_q;

    always_comb begin
        for (int s = 0; s < NS; s++) begin
            gnt_mine[s]     = gnt_i[s][MASTER_IDX];
            granted_mine[s] = granted_q_i[s][MASTER_IDX];
        end
    end

    assign err_req = req_i.req && (route_i.target == soc_xbar_pkg::TGT_ERROR);

    // At most one arbiter grants a given master, so an OR is enough
    assign rsp_o.gnt = err_req | (|gnt_mine);

    // Response phase follows any grant by exactly one cycle
    assign rsp_o.r_valid = err_q | (|granted_mine);
    assign rsp_o.r_rdata = err_q ? `SOC_ERROR_WORD : slave_rsp_i[src_q].r_rdata;
    assign rsp_o.r_opc   = err_q | slave_rsp_i[src_q].r_opc;

    // The error path never stalls, so the flag simply follows the request.
    // The source port is remembered only when a mapped grant happened
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
            src_q <= '0;
        end else begin
            err_q <= err_req;
            if (|gnt_mine) begin
                src_q <= route_i.idx;
            end
        end
    end

endmodule : tcdm_response_router

//--- verilog/tcdm_port_arbiter.sv
// Round-robin arbiter in front of one slave port
// Grant is combinational from the master requests and the slave gnt
// The slave must answer exactly one cycle after every grant it gives
// Losing requests are not dropped, the masters keep them pending
`timescale 1ns/1ps
`include "soc_xbar_macros.svh"

module tcdm_port_arbiter #(
    parameter int unsigned PORT_IDX = 0
) (
    input  logic                                           clk_i,
    input  logic                                           rst_n_i,
    input  soc_xbar_pkg::tcdm_req_t [`SOC_NR_MASTERS-1:0]  req_i,
    input  soc_xbar_pkg::route_t    [`SOC_NR_MASTERS-1:0]  route_i,
    input  soc_xbar_pkg::tcdm_rsp_t                        slave_rsp_i,
    output soc_xbar_pkg::tcdm_req_t                        slave_req_o,
    output logic                    [`SOC_NR_MASTERS-1:0]  gnt_o,
    output logic                    [`SOC_NR_MASTERS-1:0]  granted_q_o
);

    localparam int unsigned NM = `SOC_NR_MASTERS;

    // Masters that want this port in the current cycle
    logic [NM-1:0] cand;
    logic          any_cand;

    // Master with the highest priority in the next arbitration
    soc_xbar_pkg::master_sel_t rr_q;
    // Master chosen in the current cycle
    soc_xbar_pkg::master_sel_t pick;

    ////////////////////////////////////////////////////////////////////////////
    // Request collection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int m = 0; m < NM; m++) begin
            cand[m] = req_i[m].req
                   && (route_i[m].target != soc_xbar_pkg::TGT_ERROR)
                   && (route_i[m].idx == soc_xbar_pkg::slave_idx_t'(PORT_IDX));
        end
    end

    assign any_cand = |cand;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin choice
    ////////////////////////////////////////////////////////////////////////////

    // Walk from the farthest position down to the pointer so that
    // the candidate closest after the pointer is the last one to win
    always_comb begin
        pick = rr_q;
        for (int k = NM - 1; k >= 0; k--) begin
            if (cand[(int'(rr_q) + k) % NM]) begin
                pick = soc_xbar_pkg::master_sel_t'((int'(rr_q) + k) % NM);
            end
        end
    end

    // Only the chosen request reaches the slave, an idle port sees all zero
    always_comb begin
        if (any_cand) begin
            slave_req_o = req_i[pick];
        end else begin
            slave_req_o = '0;
        end
    end

    // The winner is granted in the same cycle the slave accepts
    always_comb begin
        for (int m = 0; m < NM; m++) begin
            gnt_o[m] = any_cand && slave_rsp_i.gnt
                    && (pick == soc_xbar_pkg::master_sel_t'(m));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // State
    ////////////////////////////////////////////////////////////////////////////

    // Pointer moves past the winner only when a grant really happened,
    // so a stalled slave keeps the same priority order
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_q        <= '0;
            granted_q_o <= '0;
        end else begin
            granted_q_o <= gnt_o;
            if (|gnt_o) begin
                rr_q <= soc_xbar_pkg::master_sel_t'((int'(pick) + 1) % NM);
            end
        end
    end

endmodule : tcdm_port_arbiter

//--- verilog/tcdm_addr_decoder.sv
// Address decoder for one master port, purely combinational
// Addresses are assumed word aligned, bits 1:0 take no part in the decode
// Bank selection uses the low word-address bits inside the interleaved region
// An idle request always decodes to the error target with index zero
`timescale 1ns/1ps
`include "soc_xbar_macros.svh"

module tcdm_addr_decoder (
    input  soc_xbar_pkg::tcdm_req_t req_i,
    output soc_xbar_pkg::route_t    route_o
);

    // Number of word-address bits that pick a bank
    localparam int unsigned BANK_W = $clog2(`SOC_NR_BANKS);
    // Lowest address bit of the contiguous block number
    localparam int unsigned BLK_LSB = $clog2(`SOC_CONTIG_SIZE);
    // Number of bits in the contiguous block number
    localparam int unsigned BLK_W = $clog2(`SOC_NR_CONTIG);

    // First addresses past the end of each region
    localparam logic [`SOC_ADDR_W-1:0] INTLV_END = `SOC_INTLV_BASE + `SOC_INTLV_SIZE;
    localparam logic [`SOC_ADDR_W-1:0] CONTIG_END =
        `SOC_CONTIG_BASE + `SOC_NR_CONTIG * `SOC_CONTIG_SIZE;

    logic                   in_intlv;
    logic                   in_contig;
    logic [`SOC_ADDR_W-1:0] contig_off;
    logic [BANK_W-1:0]      bank_sel;
    logic [BLK_W-1:0]       blk_sel;

    // Range checks against the fixed map
    assign in_intlv  = (req_i.add >= `SOC_INTLV_BASE) && (req_i.add < INTLV_END);
    assign in_contig = (req_i.add >= `SOC_CONTIG_BASE) && (req_i.add < CONTIG_END);

    // Bank number sits right above the byte offset of the word
    assign bank_sel = req_i.add[2 +: BANK_W];

    // Block number is taken relative to the start of the contiguous region
    assign contig_off = req_i.add - `SOC_CONTIG_BASE;
    assign blk_sel    = contig_off[BLK_LSB +: BLK_W];

    always_comb begin
        // Default is the error path, which also covers idle cycles
        route_o.target = soc_xbar_pkg::TGT_ERROR;
        route_o.idx    = '0;
        if (req_i.req && in_intlv) begin
            route_o.target = soc_xbar_pkg::TGT_INTERLEAVED;
            route_o.idx    = soc_xbar_pkg::slave_idx_t'(bank_sel);
        end else if (req_i.req && in_contig) begin
            // Contiguous slaves follow the banks on the slave port list
            route_o.target = soc_xbar_pkg::TGT_CONTIG;
            route_o.idx    = soc_xbar_pkg::slave_idx_t'(`SOC_NR_BANKS + blk_sel);
        end
    end

endmodule : tcdm_addr_decoder

//--- verilog/soc_xbar_pkg.sv
// Shared types of the TCDM interconnect
// Field widths come from the sizing macros, so include those first
// The request is about 70 bits and the response 35 bits wide
`include "soc_xbar_macros.svh"

package soc_xbar_pkg;

    // Width of a slave port index, large enough for banks and contiguous slaves
    localparam int unsigned SLAVE_IDX_W = $clog2(`SOC_NR_SLAVES);

    // Width of a master index
    localparam int unsigned MASTER_IDX_W = $clog2(`SOC_NR_MASTERS);

    ////////////////////////////////////////////////////////////////////////////
    // Bus payloads
    ////////////////////////////////////////////////////////////////////////////

    // One TCDM request, wen low means a write
    typedef struct packed {
        logic                      req;
        logic [`SOC_ADDR_W-1:0]    add;
        logic                      wen;
        logic [`SOC_DATA_W/8-1:0]  be;
        logic [`SOC_DATA_W-1:0]    wdata;
    } tcdm_req_t;

    // One TCDM response, gnt in the request cycle and the rest a cycle later
    typedef struct packed {
        logic                      gnt;
        logic                      r_valid;
        logic [`SOC_DATA_W-1:0]    r_rdata;
        logic                      r_opc;
    } tcdm_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Decode results
    ////////////////////////////////////////////////////////////////////////////

    // Kind of region an address falls into
    typedef enum logic [1:0] {
        TGT_INTERLEAVED = 2'd0,
        TGT_CONTIG      = 2'd1,
        TGT_ERROR       = 2'd2
    } target_e;

    typedef logic [SLAVE_IDX_W-1:0] slave_idx_t;

    // Where one master request goes, idx is only meaningful for mapped targets
    typedef struct packed {
        target_e    target;
        slave_idx_t idx;
    } route_t;

    typedef logic [MASTER_IDX_W-1:0] master_sel_t;

endpackage

//--- verilog/soc_xbar_macros.svh
// Fixed address map and sizing for the SoC TCDM interconnect
// Region bases must be aligned to the size of the whole region
// The bank count and the contiguous slave count must be powers of two
// Changing a value here changes the map for RTL and testbench alike
`ifndef SOC_XBAR_MACROS_SVH
`define SOC_XBAR_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Port counts
////////////////////////////////////////////////////////////////////////////

// Masters that can reach every region
`define SOC_NR_MASTERS 2
// Word-interleaved L2 banks, slave ports 0 up to NR_BANKS-1
`define SOC_NR_BANKS 4
// Contiguous slaves, placed on the slave ports after the banks
`define SOC_NR_CONTIG 2
`define SOC_NR_SLAVES (`SOC_NR_BANKS + `SOC_NR_CONTIG)

// Bus widths, the byte enable width follows from the data width
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

// Interleaved region, 16 KiB spread over the banks word by word
`define SOC_INTLV_BASE 32'h1000_0000
`define SOC_INTLV_SIZE 32'h0000_4000

// Contiguous region, each slave owns one block of this size
`define SOC_CONTIG_BASE 32'h1C00_0000
`define SOC_CONTIG_SIZE 32'h0000_1000

// Read data returned for an address that hits no region
`define SOC_ERROR_WORD 32'hBADACCE5

`endif
